// File: Bender.yml
package:
  name: led_panel_driver

sources:
  - disp_pkg.sv
  - drv_pkg.sv
  - frame_store.sv
  - column_sequencer.sv
  - lane_serializer.sv
  - gclk_gen.sv
  - column_mux.sv
  - led_panel_driver.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_led_panel_driver.sv

// File: column_mux.sv
module column_mux (
    input  logic       clock_33,
    input  logic       nrst,
    input  logic       lat,
    input  logic [2:0] lat_col,
    output logic [7:0] mux_out
);

    // Column switches only when its data is latched
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            mux_out <= '0;
        end else if (lat) begin
            mux_out <= 8'b1 << lat_col;
        end
    end

endmodule

// File: column_sequencer.sv
module column_sequencer (
    input  logic                           clock_33,
    input  logic                           nrst,
    input  logic                           position_sync,
    input  logic                           load_free,
    output logic                           driver_ready,
    output logic                           rd_en,
    output logic [disp_pkg::ADDR_BITS-1:0] rd_addr,
    output logic                           rd_valid,
    output logic [disp_pkg::COL_BITS-1:0]  col_idx
);

    logic                          busy;
    logic                          accept;
    logic [disp_pkg::CH_BITS-1:0]  ch_cnt;
    logic [disp_pkg::COL_BITS-1:0] col_cnt;

    assign driver_ready = ~busy & load_free;
    assign accept       = position_sync & driver_ready;

    assign rd_en   = busy;
    // Equals column * NUM_CHANNELS + channel for power-of-two sizes
    assign rd_addr = {col_idx, ch_cnt};

    ////////////////////////////////////////
    // Column and channel counters
    ////////////////////////////////////////
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            busy     <= 1'b0;
            ch_cnt   <= '0;
            col_cnt  <= '0;
            col_idx  <= '0;
            rd_valid <= 1'b0;
        end else begin
            // Lines up with the registered frame store read
            rd_valid <= rd_en;
            if (accept) begin
                busy    <= 1'b1;
                ch_cnt  <= '0;
                col_idx <= col_cnt;
                if (col_cnt == disp_pkg::NUM_COLUMNS - 1) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end else if (busy) begin
                ch_cnt <= ch_cnt + 1'b1;
                // Last channel of the column read
                if (ch_cnt == disp_pkg::NUM_CHANNELS - 1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: disp_pkg.sv
package disp_pkg;

    ////////////////////////////////////////
    // Panel geometry
    ////////////////////////////////////////
    localparam int NUM_COLUMNS  = 8;
    localparam int NUM_CHANNELS = 8;
    localparam int NUM_LANES    = 4;
    localparam int GRAY_BITS    = 8;

    // Index widths
    localparam int COL_BITS = 3;
    localparam int CH_BITS  = 3;

    ////////////////////////////////////////
    // Frame store
    ////////////////////////////////////////
    // One word holds the same channel of every lane
    localparam int WORD_BITS = NUM_LANES * GRAY_BITS;
    localparam int ADDR_BITS = COL_BITS + CH_BITS;

endpackage

// File: drv_pkg.sv
package drv_pkg;

    // Bits pushed into one lane for one column
    localparam int LANE_BITS      = disp_pkg::NUM_CHANNELS * disp_pkg::GRAY_BITS;
    localparam int SHIFT_CNT_BITS = 7;

    ////////////////////////////////////////
    // Grayscale clock
    ////////////////////////////////////////
    localparam int GCLK_PULSES    = 256;
    localparam int BLANKING_TIME  = 72;
    // Must hold twice GCLK_PULSES minus one
    localparam int BLANK_CNT_BITS = 9;

endpackage

// File: frame_store.sv
module frame_store (
    input  logic                           clock_33,
    input  logic                           wr_en,
    input  logic [disp_pkg::ADDR_BITS-1:0] wr_addr,
    input  logic [disp_pkg::WORD_BITS-1:0] wr_data,
    input  logic                           rd_en,
    input  logic [disp_pkg::ADDR_BITS-1:0] rd_addr,
    output logic [disp_pkg::WORD_BITS-1:0] rd_data
);

    // One word per column and channel
    logic [disp_pkg::WORD_BITS-1:0] mem [disp_pkg::NUM_COLUMNS * disp_pkg::NUM_CHANNELS];

    // Write port driven from outside
    always_ff @(posedge clock_33) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data shows up the cycle after rd_en
    always_ff @(posedge clock_33) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: gclk_gen.sv
module gclk_gen (
    input  logic clock_33,
    input  logic nrst,
    input  logic lat,
    output logic gclk,
    output logic blank_done
);

    typedef enum logic [1:0] {IDLE, BURST, BLANK} state_t;

    state_t                             state;
    logic [drv_pkg::BLANK_CNT_BITS-1:0] cnt;

    // Next latch is safe once the burst is over
    assign blank_done = (state != BURST);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state <= IDLE;
            cnt   <= '0;
            gclk  <= 1'b0;
        end else if (lat) begin
            // First pulse goes high right after lat
            state <= BURST;
            cnt   <= '0;
            gclk  <= 1'b1;
        end else begin
            case (state)
                BURST: begin
                    if (cnt == 2 * drv_pkg::GCLK_PULSES - 1) begin
                        state <= BLANK;
                        cnt   <= '0;
                        gclk  <= 1'b0;
                    end else begin
                        cnt  <= cnt + 1'b1;
                        gclk <= ~gclk;
                    end
                end
                BLANK: begin
                    if (cnt == drv_pkg::BLANKING_TIME - 1) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                IDLE:    cnt <= '0;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: lane_serializer.sv
module lane_serializer (
    input  logic                           clock_33,
    input  logic                           nrst,
    input  logic                           rd_valid,
    input  logic [disp_pkg::WORD_BITS-1:0] rd_data,
    input  logic [disp_pkg::COL_BITS-1:0]  col_idx,
    input  logic                           blank_done,
    output logic                           load_free,
    output logic                           sclk,
    output logic [disp_pkg::NUM_LANES-1:0] sin,
    output logic                           lat,
    output logic [disp_pkg::COL_BITS-1:0]  lat_col
);

    typedef enum logic [1:0] {LOAD, SHIFT, WAIT_LAT} state_t;

    state_t                              state;
    logic                                phase;
    logic [disp_pkg::CH_BITS-1:0]        load_cnt;
    logic [drv_pkg::SHIFT_CNT_BITS-1:0]  bit_cnt;
    logic [drv_pkg::LANE_BITS-1:0]       shift_reg [disp_pkg::NUM_LANES];

    // phase low means sclk low and sin settling
    assign sclk = (state == SHIFT) & phase;
    assign lat  = (state == WAIT_LAT) & blank_done;

    always_comb begin
        for (int k = 0; k < disp_pkg::NUM_LANES; k++) begin
            sin[k] = (state == SHIFT) & shift_reg[k][drv_pkg::LANE_BITS-1];
        end
    end

    ////////////////////////////////////////
    // Per-lane shift registers
    ////////////////////////////////////////
    // Words enter at the top, so channel 7 ends up at the MSB
    always_ff @(posedge clock_33) begin
        for (int k = 0; k < disp_pkg::NUM_LANES; k++) begin
            if (state == LOAD && rd_valid) begin
                shift_reg[k] <= {rd_data[k*disp_pkg::GRAY_BITS +: disp_pkg::GRAY_BITS],
                                 shift_reg[k][drv_pkg::LANE_BITS-1:disp_pkg::GRAY_BITS]};
            end else if (state == SHIFT && phase) begin
                shift_reg[k] <= shift_reg[k] << 1;
            end
        end
    end

    ////////////////////////////////////////
    // Load, shift and latch control
    ////////////////////////////////////////
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state     <= LOAD;
            phase     <= 1'b0;
            load_free <= 1'b0;
            load_cnt  <= '0;
            bit_cnt   <= '0;
            lat_col   <= '0;
        end else begin
            case (state)
                LOAD: begin
                    load_free <= ~rd_valid;
                    if (rd_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == disp_pkg::NUM_CHANNELS - 1) begin
                            state    <= SHIFT;
                            load_cnt <= '0;
                            bit_cnt  <= '0;
                            phase    <= 1'b0;
                            lat_col  <= col_idx;
                        end
                    end
                end
                SHIFT: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (bit_cnt == drv_pkg::LANE_BITS - 1) begin
                            state <= WAIT_LAT;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                WAIT_LAT: begin
                    // Hold here while the previous burst runs
                    if (blank_done) begin
                        state     <= LOAD;
                        load_free <= 1'b1;
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

endmodule

// File: led_panel_driver.sv
module led_panel_driver (
    input  logic                             clock_33,
    input  logic                             nrst,
    input  logic                             wr_en,
    input  logic [disp_pkg::ADDR_BITS-1:0]   wr_addr,
    input  logic [disp_pkg::WORD_BITS-1:0]   wr_data,
    input  logic                             position_sync,
    output logic                             driver_ready,
    output logic                             sclk,
    output logic                             lat,
    output logic                             gclk,
    output logic [disp_pkg::NUM_LANES-1:0]   sin,
    output logic [disp_pkg::NUM_COLUMNS-1:0] mux_out
);

    logic                           rd_en;
    logic                           rd_valid;
    logic                           load_free;
    logic                           blank_done;
    logic [disp_pkg::ADDR_BITS-1:0] rd_addr;
    logic [disp_pkg::WORD_BITS-1:0] rd_data;
    logic [disp_pkg::COL_BITS-1:0]  col_idx;
    logic [disp_pkg::COL_BITS-1:0]  lat_col;

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////
    frame_store frame_store_inst (
        .clock_33 (clock_33),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    column_sequencer column_sequencer_inst (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .position_sync (position_sync),
        .load_free     (load_free),
        .driver_ready  (driver_ready),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_valid      (rd_valid),
        .col_idx       (col_idx)
    );

    ////////////////////////////////////////
    // Driver chip side
    ////////////////////////////////////////
    lane_serializer lane_serializer_inst (
        .clock_33   (clock_33),
        .nrst       (nrst),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .col_idx    (col_idx),
        .blank_done (blank_done),
        .load_free  (load_free),
        .sclk       (sclk),
        .sin        (sin),
        .lat        (lat),
        .lat_col    (lat_col)
    );

    gclk_gen gclk_gen_inst (
        .clock_33   (clock_33),
        .nrst       (nrst),
        .lat        (lat),
        .gclk       (gclk),
        .blank_done (blank_done)
    );

    column_mux column_mux_inst (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .lat      (lat),
        .lat_col  (lat_col),
        .mux_out  (mux_out)
    );

endmodule

// File: tb_checker.sv
module tb_checker (
    input logic                             clock_33,
    input logic                             nrst,
    input logic                             position_sync,
    input logic                             driver_ready,
    input logic                             sclk,
    input logic                             lat,
    input logic                             gclk,
    input logic [disp_pkg::NUM_LANES-1:0]   sin,
    input logic [disp_pkg::NUM_COLUMNS-1:0] mux_out
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAT_TIMEOUT = 2000;

    // Filled by the testbench as the frame is written
    logic [disp_pkg::WORD_BITS-1:0] frame [disp_pkg::NUM_COLUMNS * disp_pkg::NUM_CHANNELS];
    logic [drv_pkg::LANE_BITS-1:0]  captured [disp_pkg::NUM_LANES];
    int                             last_col;

    int   mismatch_count = 0;
    int   other_count    = 0;
    int   accept_count   = 0;
    int   lat_count      = 0;
    int   gclk_count     = 0;
    int   sclk_count     = 0;
    int   stall_cycles   = 0;
    logic sclk_q         = 1'b0;
    logic gclk_q         = 1'b0;
    logic mux_pending    = 1'b0;
    logic accepted       = 1'b0;

    // Expected lane stream, first bit shifted out at the MSB
    function automatic logic [drv_pkg::LANE_BITS-1:0] expected_stream(int col, int lane);
        logic [drv_pkg::LANE_BITS-1:0] stream;
        stream = '0;
        for (int ch = disp_pkg::NUM_CHANNELS - 1; ch >= 0; ch--) begin
            stream = {stream[drv_pkg::LANE_BITS-disp_pkg::GRAY_BITS-1:0],
                      frame[col*disp_pkg::NUM_CHANNELS + ch][lane*disp_pkg::GRAY_BITS +:
                                                             disp_pkg::GRAY_BITS]};
        end
        return stream;
    endfunction

    function automatic logic [disp_pkg::NUM_COLUMNS-1:0] one_hot(int col);
        logic [disp_pkg::NUM_COLUMNS-1:0] sel;
        sel      = '0;
        sel[col] = 1'b1;
        return sel;
    endfunction

    ////////////////////////////////////////
    // Latch check
    ////////////////////////////////////////
    task automatic check_latch();
        int col;
        col = lat_count % disp_pkg::NUM_COLUMNS;
        if (lat_count >= accept_count) begin
            $display("Mismatch at %0t: lat without an accepted position_sync", $time);
            mismatch_count++;
        end
        if (sclk_count != drv_pkg::LANE_BITS) begin
            $display("Mismatch at %0t: %0d sclk edges before lat, expected %0d",
                     $time, sclk_count, drv_pkg::LANE_BITS);
            mismatch_count++;
        end
        for (int k = 0; k < disp_pkg::NUM_LANES; k++) begin
            if (captured[k] !== expected_stream(col, k)) begin
                $display("Mismatch at %0t: lane %0d column %0d got %h expected %h",
                         $time, k, col, captured[k], expected_stream(col, k));
                mismatch_count++;
            end
        end
        // Only a running burst has to be complete
        if (lat_count > 0 && gclk_count != drv_pkg::GCLK_PULSES) begin
            $display("Mismatch at %0t: %0d gclk pulses before lat, expected %0d",
                     $time, gclk_count, drv_pkg::GCLK_PULSES);
            mismatch_count++;
        end
        sclk_count   = 0;
        gclk_count   = 0;
        stall_cycles = 0;
        last_col     = col;
        mux_pending  = 1'b1;
        lat_count++;
    endtask

    always @(posedge clock_33) begin
        accepted = nrst && position_sync && driver_ready;
        if (accepted) begin
            accept_count++;
        end
    end

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clock_33) begin
        if (!nrst) begin
            if (sclk !== 1'b0 || lat !== 1'b0 || gclk !== 1'b0 || driver_ready !== 1'b0 ||
                sin !== '0 || mux_out !== '0) begin
                $display("Mismatch at %0t: outputs not zero in reset", $time);
                mismatch_count++;
            end
        end else begin
            // Sequencer goes busy right after it takes a pulse
            if (accepted && driver_ready !== 1'b0) begin
                $display("Mismatch at %0t: driver_ready still high after an accepted pulse",
                         $time);
                mismatch_count++;
            end
            if (mux_pending) begin
                if (mux_out !== one_hot(last_col)) begin
                    $display("Mismatch at %0t: mux_out %b expected %b",
                             $time, mux_out, one_hot(last_col));
                    mismatch_count++;
                end
                mux_pending = 1'b0;
            end
            if (sclk && !sclk_q) begin
                for (int k = 0; k < disp_pkg::NUM_LANES; k++) begin
                    captured[k] = {captured[k][drv_pkg::LANE_BITS-2:0], sin[k]};
                end
                sclk_count++;
            end
            if (gclk && !gclk_q) begin
                gclk_count++;
            end
            if (accept_count > lat_count) begin
                stall_cycles++;
            end
            if (lat) begin
                check_latch();
            end else if (stall_cycles > LAT_TIMEOUT) begin
                $display("Timeout: no lat within %0d cycles of an accepted pulse", LAT_TIMEOUT);
                other_count++;
                stall_cycles = 0;
            end
            sclk_q = sclk;
            gclk_q = gclk;
        end
    end

endmodule

// File: tb_led_panel_driver.sv
module tb_led_panel_driver;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_PULSES = 10;

    logic                             clock_33;
    logic                             nrst;
    logic                             wr_en;
    logic [disp_pkg::ADDR_BITS-1:0]   wr_addr;
    logic [disp_pkg::WORD_BITS-1:0]   wr_data;
    logic                             position_sync;
    logic                             driver_ready;
    logic                             sclk;
    logic                             lat;
    logic                             gclk;
    logic [disp_pkg::NUM_LANES-1:0]   sin;
    logic [disp_pkg::NUM_COLUMNS-1:0] mux_out;

    int seed;
    int timeouts;
    int tb_mismatches;
    int pulse_idx;
    int total_mismatches;
    int total_other;
    bit ok;

    led_panel_driver led_panel_driver_inst (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .position_sync (position_sync),
        .driver_ready  (driver_ready),
        .sclk          (sclk),
        .lat           (lat),
        .gclk          (gclk),
        .sin           (sin),
        .mux_out       (mux_out)
    );

    tb_checker checker_inst (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .position_sync (position_sync),
        .driver_ready  (driver_ready),
        .sclk          (sclk),
        .lat           (lat),
        .gclk          (gclk),
        .sin           (sin),
        .mux_out       (mux_out)
    );

    initial begin
        clock_33 = 1'b0;
        forever #20 clock_33 = ~clock_33;
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////
    task automatic write_frame();
        for (int a = 0; a < disp_pkg::NUM_COLUMNS * disp_pkg::NUM_CHANNELS; a++) begin
            @(negedge clock_33);
            wr_en   = 1'b1;
            wr_addr = a[disp_pkg::ADDR_BITS-1:0];
            wr_data = $random(seed);
            checker_inst.frame[a] = wr_data;
        end
        @(negedge clock_33);
        wr_en = 1'b0;
    endtask

    task automatic wait_ready(output bit ready);
        int n;
        n     = 0;
        ready = 1'b0;
        while (!ready && n < WAIT_LIMIT) begin
            @(negedge clock_33);
            ready = driver_ready;
            n++;
        end
        if (!ready) begin
            $display("Timeout: driver_ready stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Last column latched and its burst complete
    task automatic wait_final_burst(output bit done);
        int n;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clock_33);
            done = checker_inst.lat_count >= NUM_PULSES &&
                   checker_inst.gclk_count >= drv_pkg::GCLK_PULSES;
            n++;
        end
        if (!done) begin
            $display("Timeout: last column never latched or its gclk burst never ended");
        end
    endtask

    initial begin
        seed          = 84394;
        timeouts      = 0;
        tb_mismatches = 0;
        nrst          = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        position_sync = 1'b0;
        repeat (5) @(posedge clock_33);
        @(negedge clock_33);
        nrst = 1'b1;
        write_frame();

        for (pulse_idx = 0; pulse_idx < NUM_PULSES && timeouts == 0; pulse_idx++) begin
            wait_ready(ok);
            if (!ok) begin
                timeouts++;
            end else begin
                position_sync = 1'b1;
                @(negedge clock_33);
                // Stray repeat while the sequencer is busy
                position_sync = (pulse_idx % 3 == 0);
                @(negedge clock_33);
                position_sync = 1'b0;
            end
        end
        if (timeouts == 0) begin
            wait_final_burst(ok);
            if (!ok) begin
                timeouts++;
            end
        end

        if (checker_inst.accept_count != NUM_PULSES) begin
            $display("Mismatch at %0t: %0d pulses accepted, expected %0d",
                     $time, checker_inst.accept_count, NUM_PULSES);
            tb_mismatches++;
        end
        if (checker_inst.lat_count != NUM_PULSES) begin
            $display("Mismatch at %0t: %0d columns latched, expected %0d",
                     $time, checker_inst.lat_count, NUM_PULSES);
            tb_mismatches++;
        end

        total_mismatches = checker_inst.mismatch_count + tb_mismatches;
        total_other      = checker_inst.other_count + timeouts;
        $display("Errors: %0d mismatches, %0d other failures", total_mismatches, total_other);
        if (total_mismatches == 0 && total_other == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
disp_pkg.sv
drv_pkg.sv
frame_store.sv
column_sequencer.sv
lane_serializer.sv
gclk_gen.sv
column_mux.sv
led_panel_driver.sv
tb_checker.sv
tb_led_panel_driver.sv
